// File: design/naas_settings.svh
// Stream widths, ingress FIFO depths and one-hot source port codes
`ifndef NAAS_SETTINGS_SVH
`define NAAS_SETTINGS_SVH

// --------------------------------------------------
// Stream format
// --------------------------------------------------
`define NAAS_DATA_W     64        // tdata bits per beat
`define NAAS_STRB_W     8         // One strobe bit per data byte
`define NAAS_TUSER_W    128       // NetFPGA metadata bus

// --------------------------------------------------
// Ingress buffering
// --------------------------------------------------
`define NAAS_DATA_DEPTH 64        // Beats held per port
`define NAAS_DESC_DEPTH 8         // Finished packets waiting per port

// --------------------------------------------------
// Source port codes, one-hot as in tuser
// --------------------------------------------------
`define NAAS_PORT_A     8'h01     // MAC port A
`define NAAS_PORT_D     8'h40     // MAC port D

`endif

// File: design/axis_pkg.sv
// Stream beat struct and tuser metadata field positions
`include "naas_settings.svh"

package axis_pkg;

    // --------------------------------------------------
    // One stored beat, as held in the ingress data FIFO
    // --------------------------------------------------
    typedef struct packed {
        logic [`NAAS_DATA_W-1:0] tdata;     // Payload
        logic [`NAAS_STRB_W-1:0] tstrb;     // Valid bytes
        logic                    tlast;     // End of packet
    } axis_beat_t;

    // --------------------------------------------------
    // Metadata layout on the first beat of a packet
    // --------------------------------------------------
    localparam int TUSER_LEN_LSB = 0;       // Byte length, bits 15:0
    localparam int TUSER_SRC_LSB = 16;      // One-hot source port, bits 23:16

    // Remaining tuser bits stay zero in this design
    // Destination and user fields are left to the DMA side

endpackage

// File: design/port_pkg.sv
// Packet descriptor struct and mixer FSM state type
`include "naas_settings.svh"

package port_pkg;

    // --------------------------------------------------
    // Per-packet metadata
    // --------------------------------------------------
    typedef logic [15:0] pkt_len_t;         // Bytes in one packet
    typedef logic [7:0]  port_code_t;       // One-hot source port

    typedef struct packed {
        pkt_len_t   len;                    // Sum of set strobe bits
        port_code_t src;                    // Port the packet came in on
    } pkt_desc_t;

    // --------------------------------------------------
    // Mixer FSM
    // --------------------------------------------------
    typedef enum logic [1:0] {
        IDLE,                               // Waiting for a finished packet
        FIRST,                              // Sending the beat with metadata
        BODY                                // Sending the rest up to tlast
    } mxr_state_t;

endpackage

// File: design/axis_if.sv
// AXI-Stream bundle with source and sink modports for internal links
`timescale 1ns/1ps
`include "naas_settings.svh"

interface axis_if;

    logic [`NAAS_DATA_W-1:0]  tdata;        // Beat payload
    logic [`NAAS_STRB_W-1:0]  tstrb;        // Byte enables
    logic [`NAAS_TUSER_W-1:0] tuser;        // Metadata
    logic                     tvalid;       // Source has a beat
    logic                     tlast;        // Last beat of packet
    logic                     tready;       // Sink takes the beat

    // Driving side of the link
    modport src (
        output tdata, tstrb, tuser, tvalid, tlast,
        input  tready
    );

    // Receiving side of the link
    modport snk (
        input  tdata, tstrb, tuser, tvalid, tlast,
        output tready
    );

endinterface

// File: design/stream_fifo.sv
// Synchronous first-word-fall-through FIFO with a type-parameter payload
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic [7:0],  // Stored item
    parameter int  DEPTH     = 8            // Entries, power of two
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t wr_data,
    input  logic     wr_en,
    output logic     full,
    output payload_t rd_data,
    input  logic     rd_en,
    output logic     empty
);

    localparam int AW = $clog2(DEPTH);      // Index bits

    payload_t      mem [DEPTH];              // Storage
    logic [AW:0]   wr_ptr;                   // Extra MSB is the wrap bit
    logic [AW:0]   rd_ptr;
    logic          do_wr;
    logic          do_rd;

    assign do_wr = wr_en && !full;           // Write ignored when full
    assign do_rd = rd_en && !empty;          // Read ignored when empty

    // Same index, different lap means full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Head of queue is always on the output
    assign rd_data = mem[rd_ptr[AW-1:0]];

    // --------------------------------------------------
    // Pointers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;     // Wraps with the lap bit
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr[AW-1:0]] <= wr_data;
    end

endmodule

// File: design/port_ingress.sv
// Per-port packet buffer with byte counter and descriptor queue
`timescale 1ns/1ps
`include "naas_settings.svh"

module port_ingress
    import axis_pkg::*;
    import port_pkg::*;
#(
    parameter port_code_t PORT_CODE = `NAAS_PORT_A   // One-hot source code
) (
    input  logic                    clk,
    input  logic                    rst,
    // MAC side
    input  logic [`NAAS_DATA_W-1:0] s_tdata,
    input  logic [`NAAS_STRB_W-1:0] s_tstrb,
    input  logic                    s_tvalid,
    input  logic                    s_tlast,
    output logic                    s_tready,
    // Stored beats toward the mixer
    axis_if.src                     out,
    // Finished packets toward the mixer
    output pkt_desc_t               desc,
    output logic                    desc_valid,
    input  logic                    desc_ready
);

    axis_beat_t wr_beat;
    axis_beat_t rd_beat;
    pkt_desc_t  wr_desc;
    logic       data_full;
    logic       data_empty;
    logic       desc_full;
    logic       desc_empty;
    logic       accept;                      // Input beat moves this cycle
    pkt_len_t   byte_cnt;                    // Bytes so far in open packet
    pkt_len_t   beat_bytes;

    // Set strobe bits in one beat
    function automatic pkt_len_t strb_bytes(input logic [`NAAS_STRB_W-1:0] strb);
        pkt_len_t n;
        n = '0;
        for (int i = 0; i < `NAAS_STRB_W; i++)
            n = n + pkt_len_t'(strb[i]);
        return n;
    endfunction

    // --------------------------------------------------
    // Input side
    // --------------------------------------------------
    // Stall on either FIFO so a tlast beat always finds room for its descriptor
    assign s_tready   = !data_full && !desc_full;
    assign accept     = s_tvalid && s_tready;
    assign beat_bytes = strb_bytes(s_tstrb);

    assign wr_beat = '{tdata: s_tdata, tstrb: s_tstrb, tlast: s_tlast};
    assign wr_desc = '{len: byte_cnt + beat_bytes, src: PORT_CODE};

    always_ff @(posedge clk) begin
        if (rst)
            byte_cnt <= '0;
        else if (accept && s_tlast)
            byte_cnt <= '0;                  // Next packet starts fresh
        else if (accept)
            byte_cnt <= byte_cnt + beat_bytes;
    end

    stream_fifo #(
        .payload_t (axis_beat_t),
        .DEPTH     (`NAAS_DATA_DEPTH)
    ) data_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_data (wr_beat),
        .wr_en   (accept),
        .full    (data_full),
        .rd_data (rd_beat),
        .rd_en   (out.tvalid && out.tready),
        .empty   (data_empty)
    );

    // Pushed on the same edge as the last data beat
    stream_fifo #(
        .payload_t (pkt_desc_t),
        .DEPTH     (`NAAS_DESC_DEPTH)
    ) desc_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_data (wr_desc),
        .wr_en   (accept && s_tlast),
        .full    (desc_full),
        .rd_data (desc),
        .rd_en   (desc_valid && desc_ready),
        .empty   (desc_empty)
    );

    // --------------------------------------------------
    // Output side
    // --------------------------------------------------
    assign out.tdata  = rd_beat.tdata;
    assign out.tstrb  = rd_beat.tstrb;
    assign out.tlast  = rd_beat.tlast;
    assign out.tvalid = !data_empty;
    assign out.tuser  = '0;                  // Metadata added by the mixer
    assign desc_valid = !desc_empty;

endmodule

// File: design/mxr.sv
// Whole-packet round-robin mixer of two ports with tuser metadata insertion
`timescale 1ns/1ps
`include "naas_settings.svh"

module mxr
    import axis_pkg::*;
    import port_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    // Ingress streams
    axis_if.snk                      a_in,
    axis_if.snk                      d_in,
    // Ingress descriptors
    input  pkt_desc_t                a_desc,
    input  pkt_desc_t                d_desc,
    input  logic                     a_desc_valid,
    input  logic                     d_desc_valid,
    output logic                     a_desc_ready,
    output logic                     d_desc_ready,
    // Toward DMA
    output logic [`NAAS_DATA_W-1:0]  m_tdata,
    output logic [`NAAS_STRB_W-1:0]  m_tstrb,
    output logic [`NAAS_TUSER_W-1:0] m_tuser,
    output logic                     m_tvalid,
    output logic                     m_tlast,
    input  logic                     m_tready
);

    mxr_state_t               state;
    logic                     sel_d;         // Packet in flight is from D
    logic                     last_d;        // D was served last
    logic                     pick_d;        // Arbiter choice in IDLE
    logic                     any_desc;
    pkt_desc_t                cur_desc;      // Metadata of packet in flight
    logic                     sel_valid;
    logic                     sel_last;
    logic [`NAAS_TUSER_W-1:0] sel_tuser;
    logic [`NAAS_TUSER_W-1:0] first_tuser;
    logic                     beat_out;      // Output beat moves this cycle

    // --------------------------------------------------
    // Round-robin choice
    // --------------------------------------------------
    assign any_desc = a_desc_valid || d_desc_valid;
    assign pick_d   = d_desc_valid && (!a_desc_valid || !last_d);  // Alternate on a tie

    assign a_desc_ready = (state == IDLE) && a_desc_valid && !pick_d;
    assign d_desc_ready = (state == IDLE) && pick_d;

    // --------------------------------------------------
    // Output mux, only the chosen port is drained
    // --------------------------------------------------
    assign sel_valid = sel_d ? d_in.tvalid : a_in.tvalid;
    assign sel_last  = sel_d ? d_in.tlast  : a_in.tlast;
    assign sel_tuser = sel_d ? d_in.tuser  : a_in.tuser;

    assign m_tdata  = sel_d ? d_in.tdata : a_in.tdata;
    assign m_tstrb  = sel_d ? d_in.tstrb : a_in.tstrb;
    assign m_tlast  = sel_last;
    assign m_tvalid = (state != IDLE) && sel_valid;
    assign beat_out = m_tvalid && m_tready;

    assign a_in.tready = (state != IDLE) && !sel_d && m_tready;
    assign d_in.tready = (state != IDLE) &&  sel_d && m_tready;

    // Length and source on the first beat
    always_comb begin
        first_tuser = '0;
        first_tuser[TUSER_LEN_LSB +: $bits(pkt_len_t)]   = cur_desc.len;
        first_tuser[TUSER_SRC_LSB +: $bits(port_code_t)] = cur_desc.src;
    end

    // Body beats keep the ingress tuser, which is zero
    assign m_tuser = (state == FIRST) ? first_tuser : sel_tuser;

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            sel_d  <= 1'b0;
            last_d <= 1'b1;                  // Port A wins the first tie
        end else begin
            case (state)
                IDLE: begin
                    if (any_desc) begin
                        sel_d  <= pick_d;
                        last_d <= pick_d;
                        state  <= FIRST;
                    end
                end
                FIRST: begin
                    if (beat_out)
                        state <= sel_last ? IDLE : BODY;   // Single-beat packet ends here
                end
                BODY: begin
                    if (beat_out && sel_last)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Descriptor latched as it is popped
    always_ff @(posedge clk) begin
        if (state == IDLE && any_desc)
            cur_desc <= pick_d ? d_desc : a_desc;
    end

endmodule

// File: design/naas_rx_top.sv
// Receive merge top level with two port ingress blocks and the mixer
`timescale 1ns/1ps
`include "naas_settings.svh"

module naas_rx_top
    import port_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    // MAC port A
    input  logic [`NAAS_DATA_W-1:0]  a_tdata,
    input  logic [`NAAS_STRB_W-1:0]  a_tstrb,
    input  logic                     a_tvalid,
    input  logic                     a_tlast,
    output logic                     a_tready,
    // MAC port D
    input  logic [`NAAS_DATA_W-1:0]  d_tdata,
    input  logic [`NAAS_STRB_W-1:0]  d_tstrb,
    input  logic                     d_tvalid,
    input  logic                     d_tlast,
    output logic                     d_tready,
    // Toward DMA
    output logic [`NAAS_DATA_W-1:0]  m_tdata,
    output logic [`NAAS_STRB_W-1:0]  m_tstrb,
    output logic [`NAAS_TUSER_W-1:0] m_tuser,
    output logic                     m_tvalid,
    output logic                     m_tlast,
    input  logic                     m_tready
);

    // --------------------------------------------------
    // Ingress to mixer links
    // --------------------------------------------------
    axis_if    a_link ();                    // Port A stored beats
    axis_if    d_link ();                    // Port D stored beats
    pkt_desc_t a_desc;
    pkt_desc_t d_desc;
    logic      a_desc_valid;
    logic      d_desc_valid;
    logic      a_desc_ready;
    logic      d_desc_ready;

    port_ingress #(.PORT_CODE(`NAAS_PORT_A)) ingress_a (
        .clk        (clk),
        .rst        (rst),
        .s_tdata    (a_tdata),
        .s_tstrb    (a_tstrb),
        .s_tvalid   (a_tvalid),
        .s_tlast    (a_tlast),
        .s_tready   (a_tready),
        .out        (a_link.src),
        .desc       (a_desc),
        .desc_valid (a_desc_valid),
        .desc_ready (a_desc_ready)
    );

    port_ingress #(.PORT_CODE(`NAAS_PORT_D)) ingress_d (
        .clk        (clk),
        .rst        (rst),
        .s_tdata    (d_tdata),
        .s_tstrb    (d_tstrb),
        .s_tvalid   (d_tvalid),
        .s_tlast    (d_tlast),
        .s_tready   (d_tready),
        .out        (d_link.src),
        .desc       (d_desc),
        .desc_valid (d_desc_valid),
        .desc_ready (d_desc_ready)
    );

    // --------------------------------------------------
    // Merge toward DMA
    // --------------------------------------------------
    mxr mxr_mod (
        .clk          (clk),
        .rst          (rst),
        .a_in         (a_link.snk),
        .d_in         (d_link.snk),
        .a_desc       (a_desc),
        .d_desc       (d_desc),
        .a_desc_valid (a_desc_valid),
        .d_desc_valid (d_desc_valid),
        .a_desc_ready (a_desc_ready),
        .d_desc_ready (d_desc_ready),
        .m_tdata      (m_tdata),
        .m_tstrb      (m_tstrb),
        .m_tuser      (m_tuser),
        .m_tvalid     (m_tvalid),
        .m_tlast      (m_tlast),
        .m_tready     (m_tready)
    );

endmodule

// File: tb/naas_rx_checker.sv
// Output monitor with per-port expected packet queues, beat compare and test counts
`timescale 1ns/1ps
`include "naas_settings.svh"

module naas_rx_checker
    import axis_pkg::*;
(
    input logic                     clk,
    input logic                     rst,
    input logic [`NAAS_DATA_W-1:0]  m_tdata,
    input logic [`NAAS_STRB_W-1:0]  m_tstrb,
    input logic [`NAAS_TUSER_W-1:0] m_tuser,
    input logic                     m_tvalid,
    input logic                     m_tlast,
    input logic                     m_tready
);

    localparam int UW = `NAAS_TUSER_W;      // Common compare width

    typedef struct packed {
        logic [7:0]              port;      // One-hot source code from the stim line
        logic [`NAAS_DATA_W-1:0] seed;      // Data of beat 0
        logic [15:0]             beats;
        logic [`NAAS_STRB_W-1:0] strb;      // Strobe of the last beat
        logic [15:0]             len;       // Length expected in tuser
    } exp_pkt_t;

    exp_pkt_t exp_a [$];                    // Port A packets in stim order
    exp_pkt_t exp_d [$];                    // Port D packets in stim order
    exp_pkt_t cur;                          // Packet now on the output
    bit       in_pkt        = 1'b0;
    bit       skip_pkt      = 1'b0;         // Dropping beats of an unknown packet
    int       beat_idx      = 0;
    int       err_cnt       = 0;
    int       pkt_cnt       = 0;
    int       test_err_base = 0;
    int       test_pkt_base = 0;
    int       tests_run     = 0;
    int       tests_failed  = 0;
    string    cur_test      = "reset";

    // --------------------------------------------------
    // Test bookkeeping, called from the testbench top
    // --------------------------------------------------
    task automatic add_error(input string msg);
        $display("Error in %s: %s", cur_test, msg);
        err_cnt++;
    endtask

    task automatic expect_pkt(input logic [7:0] port, input int beats,
                              input logic [7:0] strb, input logic [63:0] seed,
                              input logic [15:0] len);
        exp_pkt_t p;
        p.port  = port;
        p.seed  = seed;
        p.beats = 16'(beats);
        p.strb  = strb;
        p.len   = len;
        if (port == `NAAS_PORT_D)
            exp_d.push_back(p);
        else
            exp_a.push_back(p);
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        test_err_base = err_cnt;
        test_pkt_base = pkt_cnt;
    endtask

    task automatic finish_test();
        int errs;
        errs = err_cnt - test_err_base;
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("Test %s: %s, %0d packets, %0d errors", cur_test,
                 (errs == 0) ? "passed" : "failed", pkt_cnt - test_pkt_base, errs);
    endtask

    task automatic report_totals();
        $display("Tests run %0d, failed %0d, packets %0d, errors %0d",
                 tests_run, tests_failed, pkt_cnt, err_cnt);
    endtask

    task automatic compare(input string what, input logic [UW-1:0] exp_v,
                           input logic [UW-1:0] act_v);
        if (exp_v !== act_v) begin
            $display("Mismatch in %s: packet %0d beat %0d %s expected %0h actual %0h",
                     cur_test, pkt_cnt, beat_idx, what, exp_v, act_v);
            err_cnt++;
        end
    endtask

    // --------------------------------------------------
    // Beat compare
    // --------------------------------------------------
    task automatic check_beat();
        logic [7:0]    src;
        logic [UW-1:0] exp_user;
        logic          exp_last;
        src      = m_tuser[TUSER_SRC_LSB +: 8];
        exp_user = '0;                      // Body beats carry no metadata
        if (skip_pkt) begin
            skip_pkt = !m_tlast;
            return;
        end
        if (!in_pkt) begin
            // Source field picks the queue
            if (src == `NAAS_PORT_A && exp_a.size() > 0)
                cur = exp_a.pop_front();
            else if (src == `NAAS_PORT_D && exp_d.size() > 0)
                cur = exp_d.pop_front();
            else begin
                add_error($sformatf("packet with source field %0h was not expected", src));
                skip_pkt = !m_tlast;
                return;
            end
            in_pkt   = 1'b1;
            beat_idx = 0;
            exp_user[TUSER_LEN_LSB +: 16] = cur.len;
            exp_user[TUSER_SRC_LSB +: 8]  = cur.port;
        end
        exp_last = (beat_idx == int'(cur.beats) - 1);
        compare("tdata", UW'(cur.seed + 64'(beat_idx)), UW'(m_tdata));
        compare("tstrb", UW'(exp_last ? cur.strb : 8'hff), UW'(m_tstrb));
        compare("tlast", UW'(exp_last), UW'(m_tlast));
        compare("tuser", exp_user, m_tuser);
        beat_idx++;
        if (m_tlast) begin
            in_pkt = 1'b0;
            pkt_cnt++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst && m_tvalid && m_tready)   // Handshake seen at the edge
            check_beat();
    end

endmodule

// File: tb/naas_rx_tb.sv
// Testbench top with clock, reset, stim file drivers, sink back-pressure and watchdog
`timescale 1ns/1ps
`include "naas_settings.svh"

module naas_rx_tb;

    localparam int    COLS        = 6;      // test, port, beats, strobe, seed, length
    localparam int    MAX_PKTS    = 64;
    localparam int    STALL_WAIT  = 200;    // Cycles allowed for a_tready to fall
    localparam int    SINK_READY  = 0;
    localparam int    SINK_RANDOM = 1;
    localparam int    SINK_STALL  = 2;
    localparam string STIM_FILE   = "tb/naas_rx_stim.txt";

    logic                     clk;
    logic                     rst;
    logic [`NAAS_DATA_W-1:0]  a_tdata;
    logic [`NAAS_STRB_W-1:0]  a_tstrb;
    logic                     a_tvalid;
    logic                     a_tlast;
    logic                     a_tready;
    logic [`NAAS_DATA_W-1:0]  d_tdata;
    logic [`NAAS_STRB_W-1:0]  d_tstrb;
    logic                     d_tvalid;
    logic                     d_tlast;
    logic                     d_tready;
    logic [`NAAS_DATA_W-1:0]  m_tdata;
    logic [`NAAS_STRB_W-1:0]  m_tstrb;
    logic [`NAAS_TUSER_W-1:0] m_tuser;
    logic                     m_tvalid;
    logic                     m_tlast;
    logic                     m_tready;

    logic [63:0] stim_mem [MAX_PKTS*COLS];  // Stim words, all ones past the end
    int          n_pkts;
    int          total_beats;
    longint      wd_ns;
    bit          armed = 1'b0;              // Watchdog starts once the file is read
    int          sink_mode;

    naas_rx_top UUT (
        .clk(clk), .rst(rst),
        .a_tdata(a_tdata), .a_tstrb(a_tstrb), .a_tvalid(a_tvalid),
        .a_tlast(a_tlast), .a_tready(a_tready),
        .d_tdata(d_tdata), .d_tstrb(d_tstrb), .d_tvalid(d_tvalid),
        .d_tlast(d_tlast), .d_tready(d_tready),
        .m_tdata(m_tdata), .m_tstrb(m_tstrb), .m_tuser(m_tuser),
        .m_tvalid(m_tvalid), .m_tlast(m_tlast), .m_tready(m_tready)
    );

    naas_rx_checker mon (
        .clk(clk), .rst(rst), .m_tdata(m_tdata), .m_tstrb(m_tstrb),
        .m_tuser(m_tuser), .m_tvalid(m_tvalid), .m_tlast(m_tlast), .m_tready(m_tready)
    );

    always #5 clk = ~clk;                   // 10 ns period

    // DMA side ready, changed on the falling edge
    always @(negedge clk) begin
        case (sink_mode)
            SINK_READY:  m_tready = 1'b1;
            SINK_RANDOM: m_tready = ($urandom % 4) != 0;   // Ready about 3 cycles in 4
            default:     m_tready = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // Stim access and port drivers
    // --------------------------------------------------
    function automatic logic [63:0] field(input int line, input int col);
        return stim_mem[line * COLS + col];
    endfunction

    function automatic logic port_ready(input logic [7:0] port);
        return (port == `NAAS_PORT_D) ? d_tready : a_tready;
    endfunction

    task automatic put_beat(input logic [7:0] port, input logic valid,
                            input logic [63:0] data, input logic [7:0] strb,
                            input logic last);
        if (port == `NAAS_PORT_D) begin
            d_tvalid = valid;
            d_tdata  = data;
            d_tstrb  = strb;
            d_tlast  = last;
        end else begin
            a_tvalid = valid;
            a_tdata  = data;
            a_tstrb  = strb;
            a_tlast  = last;
        end
    endtask

    task automatic send_packet(input int line);
        logic [7:0]  port;
        int          beats;
        logic [7:0]  strb;
        logic [63:0] seed;
        port  = 8'(field(line, 1));
        beats = int'(field(line, 2));
        strb  = 8'(field(line, 3));
        seed  = field(line, 4);
        for (int k = 0; k < beats; k++) begin
            @(negedge clk);
            put_beat(port, 1'b1, seed + 64'(k), (k == beats - 1) ? strb : 8'hff,
                     k == beats - 1);
            @(posedge clk);
            while (!port_ready(port))       // Beat held until the ingress takes it
                @(posedge clk);
        end
        @(negedge clk);
        put_beat(port, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic drive_port(input logic [7:0] port, input int test);
        for (int i = 0; i < n_pkts; i++) begin
            if (int'(field(i, 0)) == test && 8'(field(i, 1)) == port)
                send_packet(i);
        end
    endtask

    task automatic release_after_stall();
        int n;
        n = 0;
        while (a_tready && n < STALL_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (a_tready)
            mon.add_error("a_tready stayed high while the sink was stalled");
        repeat (20) @(negedge clk);         // Hold the full FIFO a while
        @(posedge clk);
        sink_mode = SINK_READY;
    endtask

    // --------------------------------------------------
    // Test sequencing
    // --------------------------------------------------
    task automatic load_stim();
        for (int i = 0; i < MAX_PKTS * COLS; i++)
            stim_mem[i] = '1;
        $readmemh(STIM_FILE, stim_mem);
        n_pkts      = 0;
        total_beats = 0;
        while (n_pkts < MAX_PKTS && stim_mem[n_pkts * COLS] != '1) begin
            total_beats += int'(field(n_pkts, 2));
            n_pkts++;
        end
        wd_ns = longint'(total_beats) * 40 * 10 + 1000;
        armed = 1'b1;
    endtask

    task automatic run_test(input int test, input string name, input int mode,
                            input bit stall);
        int target;
        target = mon.pkt_cnt;
        mon.start_test(name);
        for (int i = 0; i < n_pkts; i++) begin
            if (int'(field(i, 0)) == test) begin
                mon.expect_pkt(8'(field(i, 1)), int'(field(i, 2)), 8'(field(i, 3)),
                               field(i, 4), 16'(field(i, 5)));
                target++;
            end
        end
        @(posedge clk);
        sink_mode = mode;
        fork
            drive_port(`NAAS_PORT_A, test);
            drive_port(`NAAS_PORT_D, test);
            begin
                if (stall)
                    release_after_stall();
            end
        join
        wait (mon.pkt_cnt == target);       // All packets of this test delivered
        mon.finish_test();
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        sink_mode = SINK_READY;
        m_tready  = 1'b1;
        put_beat(`NAAS_PORT_A, 1'b0, '0, '0, 1'b0);
        put_beat(`NAAS_PORT_D, 1'b0, '0, '0, 1'b0);
        void'($urandom(32'h6d9e));
        load_stim();
        if (n_pkts == 0)
            mon.add_error("the stim file holds no packet lines");
        repeat (4) @(posedge clk);          // Reset for 4 cycles
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        if (m_tvalid !== 1'b0 || a_tready !== 1'b1 || d_tready !== 1'b1)
            mon.add_error("outputs are not idle after reset");

        run_test(1, "single_a", SINK_READY, 1'b0);
        run_test(2, "partial_d", SINK_READY, 1'b0);
        run_test(3, "dual_port", SINK_READY, 1'b0);
        run_test(4, "back_pressure", SINK_RANDOM, 1'b0);
        run_test(5, "stall_burst", SINK_STALL, 1'b1);

        repeat (50) @(posedge clk);         // Catch stray extra packets
        if (mon.pkt_cnt != n_pkts)
            mon.add_error($sformatf("%0d packets delivered but the stim file has %0d",
                                    mon.pkt_cnt, n_pkts));
        mon.report_totals();
        if (mon.err_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // Watchdog sized from the beats in the stim file
    initial begin
        wait (armed);
        #(wd_ns);
        $display("Watchdog expired after %0d ns with packets still missing", wd_ns);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: tb/naas_rx_stim.txt
// Columns, all hex: test port beats last_strobe data_seed expected_length
// port is the one-hot source code, beat k carries data_seed + k, other strobes are ff
1 01 4 ff 1111000000000000 0020
2 40 3 0f 2222000000000000 0014
2 40 1 01 2222100000000000 0001
3 01 5 ff 3333a00000000000 0028
3 40 6 7f 3333d00000000000 002f
3 01 2 3f 3333a10000000000 000e
3 40 3 01 3333d10000000000 0011
3 01 1 ff 3333a20000000000 0008
3 40 4 ff 3333d20000000000 0020
4 01 7 1f 4444a00000000000 0035
4 40 5 03 4444d00000000000 0022
4 01 3 ff 4444a10000000000 0018
4 40 2 ff 4444d10000000000 0010
4 01 1 7f 4444a20000000000 0007
4 40 8 80 4444d20000000000 0039
5 01 10 ff 5555a00000000000 0080
5 01 10 0f 5555a10000000000 007c
5 01 10 ff 5555a20000000000 0080
5 01 10 3f 5555a30000000000 007e
5 01 10 ff 5555a40000000000 0080

// File: files.f
+incdir+design
design/axis_pkg.sv
design/port_pkg.sv
design/axis_if.sv
design/stream_fifo.sv
design/port_ingress.sv
design/mxr.sv
design/naas_rx_top.sv
tb/naas_rx_checker.sv
tb/naas_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and scan the log for the fail message

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module naas_rx_tb -f files.f -o naas_rx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/naas_rx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0
